/* logic/ptc_defs.svh */
`ifndef PTC_DEFS_SVH
`define PTC_DEFS_SVH

// APB address and data widths
`define PTC_AW 12
`define PTC_DW 32

// Program and data memory, one word per entry
`define PTC_MEM_WORDS 256
`define PTC_MEM_AW 8

// Register byte addresses
`define PTC_REG_CTRL   12'h000
`define PTC_REG_STATUS 12'h004
`define PTC_REG_CYCLES 12'h008

// Memory window 0x400 to 0x7FF
`define PTC_MEM_BASE 12'h400

// Core reset hold after a start
`define PTC_BOOT_CYCLES 4

`endif

/* logic/ptc_pkg.sv */
package ptc_pkg;

  // Opcode byte, top 8 bits of an instruction word
  typedef enum logic [7:0] {
    OP_HALT = 8'h00,
    OP_LDI  = 8'h01,
    OP_LD   = 8'h02,
    OP_ST   = 8'h03,
    OP_ADD  = 8'h04,
    OP_ADDI = 8'h05,
    OP_BNZ  = 8'h06
  } ptc_op_e;

  // Memory operands and branch targets use imm[7:0]
  typedef struct packed {
    ptc_op_e     op;
    logic [23:0] imm;
  } ptc_instr_t;

  // STATUS register layout, bit 2 down to bit 0
  typedef struct packed {
    logic in_reset;
    logic halted;
    logic running;
  } ptc_status_t;

endpackage

/* logic/ptc_bus_if.sv */
`timescale 1ns/100ps
`include "ptc_defs.svh"

// Wishbone-classic style word bus between core, controller and memory
interface ptc_bus_if ();

  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [`PTC_MEM_AW-1:0] addr;
  logic [`PTC_DW-1:0]     wdata;
  logic [`PTC_DW-1:0]     rdata;
  // One-cycle pulse, rdata valid alongside
  logic                   ack;

  modport master (
    output cyc, stb, we, addr, wdata,
    input  rdata, ack
  );

  modport slave (
    input  cyc, stb, we, addr, wdata,
    output rdata, ack
  );

endinterface

/* logic/ptc_ctrl.sv */
`timescale 1ns/100ps
`include "ptc_defs.svh"

module ptc_ctrl
  import ptc_pkg::*;
(
  input  logic               clk,
  input  logic               rst_i,
  input  logic [`PTC_AW-1:0] paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`PTC_DW-1:0] pwdata_i,
  output logic [`PTC_DW-1:0] prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  input  logic               halted_i,
  output logic               core_rst_o,
  ptc_bus_if.slave           cbus,
  ptc_bus_if.master          dbus
);

  localparam int BOOT_W = $clog2(`PTC_BOOT_CYCLES + 1);
  localparam logic [`PTC_AW-1:0] WIN_MASK = `PTC_AW'(4 * `PTC_MEM_WORDS - 1);

  logic              run_q;
  logic              running_q;
  logic [BOOT_W-1:0] boot_cnt_q;
  logic [`PTC_DW-1:0] cycles_q;
  ptc_status_t       status;

  logic access;
  logic sel_ctrl;
  logic sel_status;
  logic sel_cycles;
  logic sel_mem;
  logic bad_access;
  logic host_req;
  logic ctrl_wr;
  logic start;

  // APB decode
  assign access     = psel_i & penable_i;
  assign sel_ctrl   = (paddr_i == `PTC_REG_CTRL);
  assign sel_status = (paddr_i == `PTC_REG_STATUS);
  assign sel_cycles = (paddr_i == `PTC_REG_CYCLES);
  assign sel_mem    = ((paddr_i & ~WIN_MASK) == `PTC_MEM_BASE);

  // Window only open to the host while the core sits in reset
  assign bad_access = (sel_mem & ~status.in_reset)
                    | ~(sel_ctrl | sel_status | sel_cycles | sel_mem)
                    | (pwrite_i & (sel_status | sel_cycles));

  assign host_req  = access & sel_mem & status.in_reset;
  assign pready_o  = access & (~host_req | dbus.ack);
  assign pslverr_o = access & bad_access;

  assign ctrl_wr = access & pwrite_i & sel_ctrl;
  assign start   = ctrl_wr & pwdata_i[0] & ~run_q;

  assign core_rst_o = ~running_q;
  assign status     = '{in_reset: core_rst_o, halted: halted_i, running: running_q};

  // Run bit and boot sequencer
  always_ff @(posedge clk) begin
    if (rst_i) begin
      run_q      <= 1'b0;
      running_q  <= 1'b0;
      boot_cnt_q <= '0;
    end else if (ctrl_wr && !pwdata_i[0]) begin
      run_q     <= 1'b0;
      running_q <= 1'b0;
    end else if (start) begin
      run_q      <= 1'b1;
      boot_cnt_q <= BOOT_W'(`PTC_BOOT_CYCLES - 1);
    end else if (run_q && !running_q) begin
      // Release the core when the hold runs out
      if (boot_cnt_q == '0) begin
        running_q <= 1'b1;
      end else begin
        boot_cnt_q <= boot_cnt_q - 1'b1;
      end
    end
  end

  // Run-cycle counter, frozen once the core halts
  always_ff @(posedge clk) begin
    if (rst_i || start) begin
      cycles_q <= '0;
    end else if (running_q && !halted_i) begin
      cycles_q <= cycles_q + 1'b1;
    end
  end

  always_comb begin
    prdata_o = '0;
    if (sel_ctrl) begin
      prdata_o = `PTC_DW'(run_q);
    end else if (sel_status) begin
      prdata_o = `PTC_DW'(status);
    end else if (sel_cycles) begin
      prdata_o = cycles_q;
    end else if (sel_mem) begin
      prdata_o = dbus.rdata;
    end
  end

  // Data port arbiter, core while running and host otherwise
  assign dbus.cyc   = running_q ? cbus.cyc   : host_req;
  assign dbus.stb   = running_q ? cbus.stb   : host_req;
  assign dbus.we    = running_q ? cbus.we    : pwrite_i;
  assign dbus.addr  = running_q ? cbus.addr  : paddr_i[`PTC_MEM_AW+1:2];
  assign dbus.wdata = running_q ? cbus.wdata : pwdata_i;

  assign cbus.rdata = dbus.rdata;
  assign cbus.ack   = running_q & dbus.ack;

endmodule

/* logic/ptc_mem.sv */
`timescale 1ns/100ps
`include "ptc_defs.svh"

module ptc_mem (
  input  logic     clk,
  ptc_bus_if.slave ibus,
  ptc_bus_if.slave dbus
);

  logic [`PTC_DW-1:0] mem_q [`PTC_MEM_WORDS];

  logic               ireq;
  logic               dreq;
  logic               iack_q;
  logic               dack_q;
  logic [`PTC_DW-1:0] irdata_q;
  logic [`PTC_DW-1:0] drdata_q;

  // A new request is a strobe not already being acked
  assign ireq = ibus.cyc & ibus.stb & ~iack_q;
  assign dreq = dbus.cyc & dbus.stb & ~dack_q;

  // Fixed one-cycle response on both ports
  always_ff @(posedge clk) begin
    iack_q <= ireq;
    dack_q <= dreq;
  end

  // Instruction port, read only
  always_ff @(posedge clk) begin
    if (ireq) begin
      irdata_q <= mem_q[ibus.addr];
    end
  end

  // Data port read returns the word held before a write
  always_ff @(posedge clk) begin
    if (dreq) begin
      drdata_q <= mem_q[dbus.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (dreq && dbus.we) begin
      mem_q[dbus.addr] <= dbus.wdata;
    end
  end

  assign ibus.ack   = iack_q;
  assign ibus.rdata = irdata_q;
  assign dbus.ack   = dack_q;
  assign dbus.rdata = drdata_q;

endmodule

/* logic/ptc_core.sv */
`timescale 1ns/100ps
`include "ptc_defs.svh"

module ptc_core
  import ptc_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  ptc_bus_if.master ibus,
  ptc_bus_if.master dbus,
  output logic      halted_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_IWAIT,
    S_EXEC,
    S_MEM,
    S_MWAIT,
    S_WB,
    S_HALT
  } state_e;

  state_e                 state_q;
  logic [`PTC_MEM_AW-1:0] pc_q;
  logic [`PTC_DW-1:0]     acc_q;
  ptc_op_e                op_q;
  logic [`PTC_MEM_AW-1:0] maddr_q;

  // Bus responses are taken through a register stage
  logic                   iack_q;
  logic                   dack_q;
  logic [`PTC_DW-1:0]     irdata_q;
  logic [`PTC_DW-1:0]     drdata_q;

  logic                   ireq;
  logic                   dreq;
  ptc_instr_t             instr;
  logic [`PTC_DW-1:0]     imm_sext;

  assign instr    = ptc_instr_t'(irdata_q);
  assign imm_sext = {{(`PTC_DW - 24){instr.imm[23]}}, instr.imm};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      iack_q <= 1'b0;
      dack_q <= 1'b0;
    end else begin
      iack_q <= ibus.ack;
      dack_q <= dbus.ack;
    end
  end

  always_ff @(posedge clk) begin
    irdata_q <= ibus.rdata;
    drdata_q <= dbus.rdata;
  end

  // Request held from the issue state until ack
  assign ireq       = (state_q == S_FETCH) || (state_q == S_IWAIT);
  assign ibus.cyc   = ireq;
  assign ibus.stb   = ireq;
  assign ibus.we    = 1'b0;
  assign ibus.addr  = pc_q;
  assign ibus.wdata = '0;

  assign dreq       = (state_q == S_MEM) || (state_q == S_MWAIT);
  assign dbus.cyc   = dreq;
  assign dbus.stb   = dreq;
  assign dbus.we    = dreq && (op_q == OP_ST);
  assign dbus.addr  = maddr_q;
  assign dbus.wdata = acc_q;

  // Operand capture for the memory phase
  always_ff @(posedge clk) begin
    if (state_q == S_EXEC) begin
      op_q    <= instr.op;
      maddr_q <= instr.imm[`PTC_MEM_AW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      pc_q    <= '0;
      acc_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE:  state_q <= S_FETCH;
        S_FETCH: state_q <= S_IWAIT;
        S_IWAIT: begin
          if (ibus.ack) begin
            state_q <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (iack_q) begin
            state_q <= S_FETCH;
            pc_q    <= pc_q + 1'b1;
            case (instr.op)
              OP_LDI:  acc_q <= `PTC_DW'(instr.imm);
              OP_ADDI: acc_q <= acc_q + imm_sext;
              OP_BNZ: begin
                if (acc_q != '0) begin
                  pc_q <= instr.imm[`PTC_MEM_AW-1:0];
                end
              end
              OP_LD, OP_ST, OP_ADD: begin
                state_q <= S_MEM;
                pc_q    <= pc_q;
              end
              // HALT and unknown opcodes park the core
              default: begin
                state_q <= S_HALT;
                pc_q    <= pc_q;
              end
            endcase
          end
        end
        S_MEM: state_q <= S_MWAIT;
        S_MWAIT: begin
          if (dbus.ack) begin
            state_q <= S_WB;
          end
        end
        S_WB: begin
          if (dack_q) begin
            if (op_q == OP_LD) begin
              acc_q <= drdata_q;
            end else if (op_q == OP_ADD) begin
              acc_q <= acc_q + drdata_q;
            end
            pc_q    <= pc_q + 1'b1;
            state_q <= S_FETCH;
          end
        end
        default: state_q <= S_HALT;
      endcase
    end
  end

  assign halted_o = (state_q == S_HALT);

endmodule

/* logic/ptc_top.sv */
`timescale 1ns/100ps
`include "ptc_defs.svh"

module ptc_top (
  input  logic               clk,
  input  logic               rst_i,
  input  logic [`PTC_AW-1:0] paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`PTC_DW-1:0] pwdata_i,
  output logic [`PTC_DW-1:0] prdata_o,
  output logic               pready_o,
  output logic               pslverr_o
);

  logic core_rst;
  logic halted;

  // Core instruction fetch straight to memory
  ptc_bus_if ibus ();
  // Core data port, routed through the controller
  ptc_bus_if cbus ();
  // Arbitrated memory data port
  ptc_bus_if dbus ();

  ptc_ctrl u_ctrl (
    .clk        (clk),
    .rst_i      (rst_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .halted_i   (halted),
    .core_rst_o (core_rst),
    .cbus       (cbus),
    .dbus       (dbus)
  );

  ptc_core u_core (
    .clk      (clk),
    .rst_i    (core_rst),
    .ibus     (ibus),
    .dbus     (cbus),
    .halted_o (halted)
  );

  ptc_mem u_mem (
    .clk  (clk),
    .ibus (ibus),
    .dbus (dbus)
  );

endmodule

/* verif/ptc_chk.sv */
`timescale 1ns/100ps

module ptc_chk (
  input logic clk,
  input logic rst_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  ptc_bus_if  ibus,
  ptc_bus_if  cbus,
  ptc_bus_if  dbus
);

  // Slave acks only an open strobe
  ibus_ack_a: assert property (@(posedge clk) disable iff (rst_i)
    ibus.ack |-> ibus.stb) else $error("ibus ack without stb");
  cbus_ack_a: assert property (@(posedge clk) disable iff (rst_i)
    cbus.ack |-> cbus.stb) else $error("cbus ack without stb");
  dbus_ack_a: assert property (@(posedge clk) disable iff (rst_i)
    dbus.ack |-> dbus.stb) else $error("dbus ack without stb");

  // Request held steady until acked
  ibus_hold_a: assert property (@(posedge clk) disable iff (rst_i)
    ibus.stb && !ibus.ack |=> ibus.stb && $stable(ibus.addr))
    else $error("ibus request dropped or changed before ack");
  cbus_hold_a: assert property (@(posedge clk) disable iff (rst_i)
    cbus.stb && !cbus.ack |=> cbus.stb && $stable(cbus.addr) && $stable(cbus.we))
    else $error("cbus request dropped or changed before ack");
  dbus_hold_a: assert property (@(posedge clk) disable iff (rst_i)
    dbus.stb && !dbus.ack |=> dbus.stb && $stable(dbus.addr) && $stable(dbus.we))
    else $error("dbus request dropped or changed before ack");

  // Slave error only in the cycle that completes a transfer
  apb_err_a: assert property (@(posedge clk) disable iff (rst_i)
    pslverr_i |-> psel_i && penable_i && pready_i)
    else $error("APB error outside a completing access cycle");

endmodule

bind ptc_top ptc_chk u_chk (
  .clk       (clk),
  .rst_i     (rst_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .ibus      (ibus),
  .cbus      (cbus),
  .dbus      (dbus)
);

/* verif/ptc_tb.sv */
`timescale 1ns/100ps
`include "ptc_defs.svh"

module ptc_tb
  import ptc_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // Up to 800 transfers of 4 cycles and four runs of about 600 cycles with a margin of four
  localparam int XFER_CYCLES     = 4;
  localparam int MAX_XFERS       = 800;
  localparam int RUN_CYCLES      = 600;
  localparam int WATCHDOG_CYCLES = 4 * (MAX_XFERS * XFER_CYCLES + 4 * RUN_CYCLES);
  localparam int POLL_LIMIT      = 400;

  // Memory window size in bytes, one word per 4 bytes
  localparam int WIN_BYTES = 4 * `PTC_MEM_WORDS;

  // STATUS values: in_reset is bit 2, halted bit 1, running bit 0
  localparam logic [`PTC_DW-1:0] ST_RESET   = 32'h4;
  localparam logic [`PTC_DW-1:0] ST_RUNNING = 32'h1;
  localparam logic [`PTC_DW-1:0] ST_HALTED  = 32'h3;

  localparam logic [7:0] DATA_ADDR  = 8'h80;
  localparam logic [7:0] SUM_ADDR   = 8'h90;
  localparam logic [7:0] CNT_ADDR   = 8'h91;
  localparam logic [7:0] GUARD_ADDR = 8'hA0;

  logic               clk;
  logic               rst_i;
  logic [`PTC_AW-1:0] paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [`PTC_DW-1:0] pwdata;
  logic [`PTC_DW-1:0] prdata;
  logic               pready;
  logic               pslverr;
  int                 checks;
  int                 errors;

  ptc_top uut (
    .clk       (clk),
    .rst_i     (rst_i),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [`PTC_AW-1:0] win_addr(input logic [7:0] idx);
    return `PTC_MEM_BASE + {idx, 2'b00};
  endfunction

  function automatic logic [`PTC_DW-1:0] encode(input ptc_op_e op, input logic [23:0] imm);
    return {op, imm};
  endfunction

  // One APB transfer with outputs sampled on the falling edge
  task automatic apb_xfer(input logic wr, input logic [`PTC_AW-1:0] addr,
                          input logic [`PTC_DW-1:0] wdata,
                          output logic [`PTC_DW-1:0] rdata, output logic err);
    int   waits;
    logic in_window;
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    // Accepted window accesses wait one cycle for the memory ack
    in_window = (int'(addr) >= int'(`PTC_MEM_BASE))
              && (int'(addr) < int'(`PTC_MEM_BASE) + WIN_BYTES);
    checks++;
    if (waits != ((in_window && !err) ? 1 : 0)) begin
      errors++;
      $display("MISMATCH at %0t ns: %0d wait cycles at address %h", $time, waits, addr);
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`PTC_AW-1:0] addr, input logic [`PTC_DW-1:0] data,
                           output logic err);
    logic [`PTC_DW-1:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`PTC_AW-1:0] addr, output logic [`PTC_DW-1:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic check_word(input string what, input logic [`PTC_DW-1:0] got,
                            input logic [`PTC_DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic read_expect(input string what, input logic [`PTC_AW-1:0] addr,
                             input logic [`PTC_DW-1:0] exp, input logic exp_err);
    logic [`PTC_DW-1:0] data;
    logic               err;
    apb_read(addr, data, err);
    check_word({what, " pslverr"}, {31'b0, err}, {31'b0, exp_err});
    if (!exp_err) begin
      check_word(what, data, exp);
    end
  endtask

  task automatic write_expect(input string what, input logic [`PTC_AW-1:0] addr,
                              input logic [`PTC_DW-1:0] data, input logic exp_err);
    logic err;
    apb_write(addr, data, err);
    check_word({what, " pslverr"}, {31'b0, err}, {31'b0, exp_err});
  endtask

  // Poll STATUS until any bit of mask is set
  task automatic wait_status(input string what, input logic [2:0] mask);
    logic [`PTC_DW-1:0] data;
    logic               err;
    int                 polls;
    polls = 0;
    data  = '0;
    while ((data[2:0] & mask) == '0 && polls < POLL_LIMIT) begin
      apb_read(`PTC_REG_STATUS, data, err);
      polls++;
    end
    if ((data[2:0] & mask) == '0) begin
      errors++;
      $display("Core never reached %s within %0d status polls", what, POLL_LIMIT);
    end
  endtask

  // Sums mem[0x80..0x87] into mem[0x90]
  // The ADD at word 5 steps its own address
  task automatic load_program();
    logic [`PTC_DW-1:0] prog [15];
    prog = '{
      encode(OP_LDI,  24'd0),
      encode(OP_ST,   {16'd0, SUM_ADDR}),
      encode(OP_LDI,  24'd8),
      encode(OP_ST,   {16'd0, CNT_ADDR}),
      encode(OP_LD,   {16'd0, SUM_ADDR}),
      encode(OP_ADD,  {16'd0, DATA_ADDR}),
      encode(OP_ST,   {16'd0, SUM_ADDR}),
      encode(OP_LD,   24'd5),
      encode(OP_ADDI, 24'd1),
      encode(OP_ST,   24'd5),
      encode(OP_LD,   {16'd0, CNT_ADDR}),
      encode(OP_ADDI, 24'hFF_FFFF),
      encode(OP_ST,   {16'd0, CNT_ADDR}),
      encode(OP_BNZ,  24'd4),
      encode(OP_HALT, 24'd0)
    };
    foreach (prog[i]) begin
      write_expect("program load", win_addr(8'(i)), prog[i], 1'b0);
    end
  endtask

  task automatic load_data(output logic [`PTC_DW-1:0] sum);
    logic [`PTC_DW-1:0] value;
    sum = '0;
    for (int i = 0; i < 8; i++) begin
      value = $urandom;
      sum += value;
      write_expect("data load", win_addr(DATA_ADDR + 8'(i)), value, 1'b0);
    end
  endtask

  task automatic run_to_halt();
    write_expect("run start", `PTC_REG_CTRL, 32'h1, 1'b0);
    wait_status("halt", 3'b010);
    write_expect("run stop", `PTC_REG_CTRL, 32'h0, 1'b0);
  endtask

  task automatic test_reset_state();
    read_expect("STATUS after reset", `PTC_REG_STATUS, ST_RESET, 1'b0);
    read_expect("CYCLES after reset", `PTC_REG_CYCLES, '0, 1'b0);
    read_expect("CTRL after reset", `PTC_REG_CTRL, '0, 1'b0);
    read_expect("unmapped read", 12'h010, '0, 1'b1);
    write_expect("STATUS write", `PTC_REG_STATUS, 32'h1, 1'b1);
    write_expect("CYCLES write", `PTC_REG_CYCLES, 32'h1, 1'b1);
  endtask

  task automatic test_memory_load();
    logic [7:0]         idx [16];
    logic [`PTC_DW-1:0] model [`PTC_MEM_WORDS];
    logic [`PTC_DW-1:0] value;
    for (int i = 0; i < 16; i++) begin
      idx[i]        = 8'($urandom);
      value         = $urandom;
      model[idx[i]] = value;
      write_expect("window write", win_addr(idx[i]), value, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      read_expect("window read back", win_addr(idx[i]), model[idx[i]], 1'b0);
    end
  endtask

  task automatic test_program_run();
    logic [`PTC_DW-1:0] sum;
    load_program();
    load_data(sum);
    run_to_halt();
    read_expect("sum word", win_addr(SUM_ADDR), sum, 1'b0);
  endtask

  task automatic test_access_while_running();
    load_program();
    write_expect("guard word", win_addr(GUARD_ADDR), 32'h5a5a_0f0f, 1'b0);
    write_expect("run start", `PTC_REG_CTRL, 32'h1, 1'b0);
    wait_status("running", 3'b001);
    read_expect("STATUS while running", `PTC_REG_STATUS, ST_RUNNING, 1'b0);
    write_expect("window write while running", win_addr(GUARD_ADDR), 32'hdead_beef, 1'b1);
    read_expect("window read while running", win_addr(GUARD_ADDR), '0, 1'b1);
    wait_status("halt", 3'b010);
    read_expect("STATUS after halt", `PTC_REG_STATUS, ST_HALTED, 1'b0);
    write_expect("run stop", `PTC_REG_CTRL, 32'h0, 1'b0);
    read_expect("guard word after run", win_addr(GUARD_ADDR), 32'h5a5a_0f0f, 1'b0);
  endtask

  task automatic test_cycle_counter();
    logic [`PTC_DW-1:0] first;
    logic [`PTC_DW-1:0] second;
    logic               err;
    load_program();
    write_expect("run start", `PTC_REG_CTRL, 32'h1, 1'b0);
    wait_status("halt", 3'b010);
    // Both reads land while the core sits halted
    apb_read(`PTC_REG_CYCLES, first, err);
    check_word("CYCLES first pslverr", {31'b0, err}, '0);
    apb_read(`PTC_REG_CYCLES, second, err);
    check_word("CYCLES second pslverr", {31'b0, err}, '0);
    check_word("CYCLES second read", second, first);
    checks++;
    if (first == '0) begin
      errors++;
      $display("MISMATCH at %0t ns: CYCLES reads zero after a run", $time);
    end
    write_expect("run stop", `PTC_REG_CTRL, 32'h0, 1'b0);
  endtask

  task automatic test_restart();
    logic [`PTC_DW-1:0] sum;
    write_expect("run stop", `PTC_REG_CTRL, 32'h0, 1'b0);
    read_expect("STATUS after stop", `PTC_REG_STATUS, ST_RESET, 1'b0);
    load_program();
    load_data(sum);
    run_to_halt();
    read_expect("sum word after restart", win_addr(SUM_ADDR), sum, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h52ab_aa19));
    clk     = 1'b0;
    rst_i   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    checks  = 0;
    errors  = 0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    test_reset_state();
    test_memory_load();
    test_program_run();
    test_access_while_running();
    test_cycle_counter();
    test_restart();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/ptc_pkg.sv
logic/ptc_bus_if.sv
logic/ptc_ctrl.sv
logic/ptc_mem.sv
logic/ptc_core.sv
logic/ptc_top.sv
verif/ptc_chk.sv
verif/ptc_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ptc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vptc_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
